// ==== verilog/fc_cfg_pkg.sv ====
`default_nettype none

package fc_cfg_pkg;

	localparam int REG_ADDR_W = 2;
	localparam int REG_DATA_W = 8;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [REG_DATA_W-1:0] reg_data_t;

	// register map
	localparam reg_addr_t REG_MODE    = 2'd0;
	localparam reg_addr_t REG_CLOCK   = 2'd1;
	localparam reg_addr_t REG_INT_CNT = 2'd2; // read only, write clears
	localparam reg_addr_t REG_EXT_CNT = 2'd3; // read only, write clears

	// REG_MODE fields
	localparam int MODE_EDGE_SEL = 0; // 1 selects the falling sample
	localparam int MODE_POLARITY = 1; // 0 inverts the command

	// REG_CLOCK fields
	localparam int CLK_INT_SELECT    = 0;
	localparam int CLK_FC_INT_SELECT = 1;
	localparam int CLK_EXT_ACTIVE    = 2; // status, read only

	// non-inverting, rising edge
	localparam reg_data_t MODE_RESET  = 8'h02;
	localparam reg_data_t CLOCK_RESET = 8'h00;

endpackage

`default_nettype wire

// ==== verilog/fc_cmd_pkg.sv ====
`default_nettype none

package fc_cmd_pkg;

	localparam int NFANOUT     = 4;
	localparam int ACT_COUNT_W = 8;
	localparam int SYNC_STAGES = 2; // flops after the input register

	typedef logic [NFANOUT-1:0]     fanout_t;
	typedef logic [ACT_COUNT_W-1:0] act_count_t;

	// channels 0 and 2 leave the board inverted
	localparam fanout_t FANOUT_INVERT = 4'b0101;

	// next value of an activity counter, clear has priority over a count
	function automatic act_count_t act_count_next(
		input act_count_t count,
		input logic       rise,
		input logic       clr
	);
		act_count_t next;
		if (clr)
			next = '0;
		else if (rise)
			next = count + 1'b1; // wraps at the top
		else
			next = count;
		return next;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/fc_ctrl_if.sv ====
`default_nettype none

// configuration controls from the register bank to the command paths
interface fc_ctrl_if;

	logic edge_sel;    // external capture edge
	logic polarity;    // 0 inverts the chosen command
	logic fc_int_select;
	logic int_cnt_clr; // one-cycle strobe
	logic ext_cnt_clr; // one-cycle strobe

	modport regs (
		output edge_sel,
		output polarity,
		output fc_int_select,
		output int_cnt_clr,
		output ext_cnt_clr
	);

	modport int_path (
		input int_cnt_clr
	);

	modport ext_path (
		input edge_sel,
		input ext_cnt_clr
	);

	modport combine (
		input polarity,
		input fc_int_select
	);

endinterface

`default_nettype wire

// ==== verilog/fc_config_regs.sv ====
`default_nettype none

module fc_config_regs import fc_cfg_pkg::*, fc_cmd_pkg::*; (
	input  logic       sel_fast_clock,
	input  logic       rst_n,
	input  logic       cfg_wr,
	input  logic       cfg_rd,
	input  reg_addr_t  cfg_addr,
	input  reg_data_t  cfg_wdata,
	output reg_data_t  cfg_rdata,
	output logic       cfg_rvalid,
	output logic       clk_int_select,
	input  logic       clk_ext_active,
	input  act_count_t int_count,
	input  act_count_t ext_count,
	fc_ctrl_if.regs    ctrl
);

	logic edge_sel_q;
	logic polarity_q;
	logic clk_int_sel_q;
	logic fc_int_sel_q;
	logic mode_wr;
	logic clock_wr;
	reg_data_t rd_value;

	assign mode_wr  = cfg_wr && (cfg_addr == REG_MODE);
	assign clock_wr = cfg_wr && (cfg_addr == REG_CLOCK);

	// writable mode and clock bits
	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n) begin
			edge_sel_q    <= MODE_RESET[MODE_EDGE_SEL];
			polarity_q    <= MODE_RESET[MODE_POLARITY];
			clk_int_sel_q <= CLOCK_RESET[CLK_INT_SELECT];
			fc_int_sel_q  <= CLOCK_RESET[CLK_FC_INT_SELECT];
		end else begin
			if (mode_wr) begin
				edge_sel_q <= cfg_wdata[MODE_EDGE_SEL];
				polarity_q <= cfg_wdata[MODE_POLARITY];
			end
			if (clock_wr) begin
				clk_int_sel_q <= cfg_wdata[CLK_INT_SELECT];
				fc_int_sel_q  <= cfg_wdata[CLK_FC_INT_SELECT];
			end
		end
	end

	// read value, unused bits read as zero
	always_comb begin
		rd_value = '0;
		case (cfg_addr)
			REG_MODE: begin
				rd_value[MODE_EDGE_SEL] = edge_sel_q;
				rd_value[MODE_POLARITY] = polarity_q;
			end
			REG_CLOCK: begin
				rd_value[CLK_INT_SELECT]    = clk_int_sel_q;
				rd_value[CLK_FC_INT_SELECT] = fc_int_sel_q;
				rd_value[CLK_EXT_ACTIVE]    = clk_ext_active; // live status
			end
			REG_INT_CNT: rd_value = int_count;
			REG_EXT_CNT: rd_value = ext_count;
		endcase
	end

	// read data lands one cycle after the strobe
	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n) begin
			cfg_rvalid <= 1'b0;
			cfg_rdata  <= '0;
		end else begin
			cfg_rvalid <= cfg_rd;
			if (cfg_rd)
				cfg_rdata <= rd_value; // old value on a same-edge write
		end
	end

	assign clk_int_select = clk_int_sel_q;

	assign ctrl.edge_sel      = edge_sel_q;
	assign ctrl.polarity      = polarity_q;
	assign ctrl.fc_int_select = fc_int_sel_q;
	// a write to a counter address clears it on the same edge it is sampled
	assign ctrl.int_cnt_clr   = cfg_wr && (cfg_addr == REG_INT_CNT);
	assign ctrl.ext_cnt_clr   = cfg_wr && (cfg_addr == REG_EXT_CNT);

endmodule

`default_nettype wire

// ==== verilog/int_command_sync.sv ====
`default_nettype none

module int_command_sync import fc_cmd_pkg::*; (
	input  logic         sel_fast_clock,
	input  logic         rst_n,
	input  logic         int_fast_command,
	fc_ctrl_if.int_path  ctrl,
	output logic         fc_from_int,
	output act_count_t   int_count
);

	logic                   in_q;   // source-side input register
	logic [SYNC_STAGES-1:0] sync_q; // bit 0 is the first stage
	logic                   prev_q;
	logic                   rise;

	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n) begin
			in_q   <= 1'b0;
			sync_q <= '0;
		end else begin
			in_q   <= int_fast_command;
			sync_q <= {sync_q[SYNC_STAGES-2:0], in_q};
		end
	end

	assign fc_from_int = sync_q[SYNC_STAGES-1];

	// activity count on rising edges of the synchronised bit
	assign rise = fc_from_int && !prev_q;

	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n) begin
			prev_q    <= 1'b0;
			int_count <= '0;
		end else begin
			prev_q    <= fc_from_int;
			int_count <= act_count_next(int_count, rise, ctrl.int_cnt_clr);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ext_command_capture.sv ====
`default_nettype none

module ext_command_capture import fc_cmd_pkg::*; (
	input  logic         sel_fast_clock,
	input  logic         rst_n,
	input  logic         ext_rise,
	input  logic         ext_fall,
	fc_ctrl_if.ext_path  ctrl,
	output logic         fc_from_ext,
	output act_count_t   ext_count
);

	logic rise_q; // sample taken on the rising clock edge
	logic fall_q; // sample taken on the falling clock edge
	logic prev_q;
	logic rise;

	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n) begin
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end else begin
			rise_q <= ext_rise;
			fall_q <= ext_fall;
		end
	end

	assign fc_from_ext = ctrl.edge_sel ? fall_q : rise_q;

	assign rise = fc_from_ext && !prev_q;

	// same counting rule as the internal path
	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n) begin
			prev_q    <= 1'b0;
			ext_count <= '0;
		end else begin
			prev_q    <= fc_from_ext;
			ext_count <= act_count_next(ext_count, rise, ctrl.ext_cnt_clr);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/command_fanout.sv ====
`default_nettype none

module command_fanout import fc_cmd_pkg::*; (
	input  logic        sel_fast_clock,
	input  logic        rst_n,
	input  logic        fc_from_int,
	input  logic        fc_from_ext,
	input  logic        clk_ext_active,
	fc_ctrl_if.combine  ctrl,
	output logic        fast_command_out,
	output fanout_t     fast_command_fanout
);

	logic use_int_q; // 1 selects the internal path
	logic fc_sel;

	// without an active external clock the internal path is forced
	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n)
			use_int_q <= 1'b1;
		else
			use_int_q <= !clk_ext_active || ctrl.fc_int_select;
	end

	assign fc_sel = use_int_q ? fc_from_int : fc_from_ext;

	assign fast_command_out = ctrl.polarity ? fc_sel : !fc_sel;

	// output register per channel, fixed inversion per board routing
	always_ff @(posedge sel_fast_clock or negedge rst_n) begin
		if (!rst_n)
			fast_command_fanout <= '0;
		else
			fast_command_fanout <= {NFANOUT{fast_command_out}} ^ FANOUT_INVERT;
	end

endmodule

`default_nettype wire

// ==== verilog/fast_control_fanout.sv ====
`default_nettype none

module fast_control_fanout import fc_cfg_pkg::*, fc_cmd_pkg::*; (
	input  logic      sel_fast_clock,
	input  logic      rst_n,

	// register access
	input  logic      cfg_wr,
	input  logic      cfg_rd,
	input  reg_addr_t cfg_addr,
	input  reg_data_t cfg_wdata,
	output reg_data_t cfg_rdata,
	output logic      cfg_rvalid,

	// clock status and select
	input  logic      clk_ext_active,
	output logic      clk_int_select,

	// command inputs
	input  logic      int_fast_command,
	input  logic      ext_rise,
	input  logic      ext_fall,

	// command outputs
	output logic      fast_command_out,
	output fanout_t   fast_command_fanout
);

	logic       fc_from_int;
	logic       fc_from_ext;
	act_count_t int_count;
	act_count_t ext_count;

	fc_ctrl_if ctrl ();

	fc_config_regs u_regs (
		.sel_fast_clock (sel_fast_clock),
		.rst_n          (rst_n),
		.cfg_wr         (cfg_wr),
		.cfg_rd         (cfg_rd),
		.cfg_addr       (cfg_addr),
		.cfg_wdata      (cfg_wdata),
		.cfg_rdata      (cfg_rdata),
		.cfg_rvalid     (cfg_rvalid),
		.clk_int_select (clk_int_select),
		.clk_ext_active (clk_ext_active),
		.int_count      (int_count),
		.ext_count      (ext_count),
		.ctrl           (ctrl.regs)
	);

	int_command_sync u_int_path (
		.sel_fast_clock   (sel_fast_clock),
		.rst_n            (rst_n),
		.int_fast_command (int_fast_command),
		.ctrl             (ctrl.int_path),
		.fc_from_int      (fc_from_int),
		.int_count        (int_count)
	);

	ext_command_capture u_ext_path (
		.sel_fast_clock (sel_fast_clock),
		.rst_n          (rst_n),
		.ext_rise       (ext_rise),
		.ext_fall       (ext_fall),
		.ctrl           (ctrl.ext_path),
		.fc_from_ext    (fc_from_ext),
		.ext_count      (ext_count)
	);

	command_fanout u_fanout (
		.sel_fast_clock      (sel_fast_clock),
		.rst_n               (rst_n),
		.fc_from_int         (fc_from_int),
		.fc_from_ext         (fc_from_ext),
		.clk_ext_active      (clk_ext_active),
		.ctrl                (ctrl.combine),
		.fast_command_out    (fast_command_out),
		.fast_command_fanout (fast_command_fanout)
	);

endmodule

`default_nettype wire

// ==== verif/fast_control_fanout_tb.sv ====
`default_nettype none

module fast_control_fanout_tb import fc_cfg_pkg::*, fc_cmd_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_HALF       = 20; // 40 ns period
	localparam int          RESET_CYCLES   = 10;
	localparam int          PHASE_CYCLES   = 1000;
	localparam int          NUM_PHASES     = 4;
	localparam int          TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 1000;
	localparam int unsigned SEED           = 32'h487373ac;

	logic      sel_fast_clock;
	logic      rst_n;
	logic      cfg_wr;
	logic      cfg_rd;
	reg_addr_t cfg_addr;
	reg_data_t cfg_wdata;
	reg_data_t cfg_rdata;
	logic      cfg_rvalid;
	logic      clk_ext_active;
	logic      clk_int_select;
	logic      int_fast_command;
	logic      ext_rise;
	logic      ext_fall;
	logic      fast_command_out;
	fanout_t   fast_command_fanout;

	// reference model state
	logic       m_in_q;
	logic       m_sync1;
	logic       m_sync2; // model of fc_from_int
	logic       m_int_prev;
	act_count_t m_int_cnt;
	logic       m_rise_q;
	logic       m_fall_q;
	logic       m_ext_prev;
	act_count_t m_ext_cnt;
	logic       m_edge_sel;
	logic       m_polarity;
	logic       m_clk_int_sel;
	logic       m_fc_int_sel;
	logic       m_use_int;
	fanout_t    m_fanout;
	logic       m_rvalid;
	reg_data_t  m_rdata;

	int          out_errors    = 0;
	int          fanout_errors = 0;
	int          reg_errors    = 0;
	int          cycle_count   = 0;
	int unsigned rng_seed;

	fast_control_fanout dut (
		.sel_fast_clock      (sel_fast_clock),
		.rst_n               (rst_n),
		.cfg_wr              (cfg_wr),
		.cfg_rd              (cfg_rd),
		.cfg_addr            (cfg_addr),
		.cfg_wdata           (cfg_wdata),
		.cfg_rdata           (cfg_rdata),
		.cfg_rvalid          (cfg_rvalid),
		.clk_ext_active      (clk_ext_active),
		.clk_int_select      (clk_int_select),
		.int_fast_command    (int_fast_command),
		.ext_rise            (ext_rise),
		.ext_fall            (ext_fall),
		.fast_command_out    (fast_command_out),
		.fast_command_fanout (fast_command_fanout)
	);

	initial begin
		sel_fast_clock = 1'b0;
		forever #CLK_HALF sel_fast_clock = ~sel_fast_clock;
	end

	// command as seen on fast_command_out for the current model state
	function automatic logic model_command();
		logic ext_src;
		logic src;
		ext_src = m_edge_sel ? m_fall_q : m_rise_q;
		src     = m_use_int ? m_sync2 : ext_src;
		return m_polarity ? src : ~src; // polarity 0 inverts
	endfunction

	function automatic reg_data_t read_value(input reg_addr_t addr);
		reg_data_t v;
		case (addr)
			REG_MODE:    v = {6'b0, m_polarity, m_edge_sel};
			REG_CLOCK:   v = {5'b0, clk_ext_active, m_fc_int_sel, m_clk_int_sel};
			REG_INT_CNT: v = m_int_cnt;
			default:     v = m_ext_cnt;
		endcase
		return v;
	endfunction

	task automatic reset_model();
		{m_in_q, m_sync1, m_sync2, m_int_prev} = 4'b0;
		{m_rise_q, m_fall_q, m_ext_prev}       = 3'b0;
		m_int_cnt     = '0;
		m_ext_cnt     = '0;
		m_edge_sel    = 1'b0; // rising edge
		m_polarity    = 1'b1; // non-inverting
		m_clk_int_sel = 1'b0;
		m_fc_int_sel  = 1'b0;
		m_use_int     = 1'b1;
		m_fanout      = '0;
		m_rvalid      = 1'b0;
		m_rdata       = '0;
	endtask

	// one rising edge of the model with inputs as the DUT samples them
	task automatic advance_model();
		logic      cmd;
		logic      int_rise;
		logic      ext_src;
		logic      ext_up;
		reg_data_t rd_value;
		cmd      = model_command();
		int_rise = m_sync2 & ~m_int_prev;
		ext_src  = m_edge_sel ? m_fall_q : m_rise_q;
		ext_up   = ext_src & ~m_ext_prev;
		rd_value = read_value(cfg_addr); // value before any same-edge write
		m_rvalid = cfg_rd;
		if (cfg_rd)
			m_rdata = rd_value;
		if (cfg_wr && cfg_addr == REG_INT_CNT)
			m_int_cnt = '0; // clear beats a count
		else if (int_rise)
			m_int_cnt = m_int_cnt + 8'd1;
		if (cfg_wr && cfg_addr == REG_EXT_CNT)
			m_ext_cnt = '0;
		else if (ext_up)
			m_ext_cnt = m_ext_cnt + 8'd1;
		m_int_prev = m_sync2;
		m_ext_prev = ext_src;
		m_sync2    = m_sync1;
		m_sync1    = m_in_q;
		m_in_q     = int_fast_command;
		m_rise_q   = ext_rise;
		m_fall_q   = ext_fall;
		for (int ch = 0; ch < NFANOUT; ch++)
			m_fanout[ch] = FANOUT_INVERT[ch] ? ~cmd : cmd;
		m_use_int = ~clk_ext_active | m_fc_int_sel; // old select bit
		if (cfg_wr && cfg_addr == REG_MODE) begin
			m_edge_sel = cfg_wdata[0];
			m_polarity = cfg_wdata[1];
		end
		if (cfg_wr && cfg_addr == REG_CLOCK) begin
			m_clk_int_sel = cfg_wdata[0];
			m_fc_int_sel  = cfg_wdata[1];
		end
	endtask

	task automatic check_outputs();
		logic exp_cmd;
		exp_cmd = model_command();
		if (fast_command_out !== exp_cmd) begin
			$display("ERROR fast_command_out: got %h expected %h at %0t",
				fast_command_out, exp_cmd, $time);
			out_errors++;
		end
		if (fast_command_fanout !== m_fanout) begin
			$display("ERROR fast_command_fanout: got %h expected %h at %0t",
				fast_command_fanout, m_fanout, $time);
			fanout_errors++;
		end
		if (clk_int_select !== m_clk_int_sel) begin
			$display("ERROR clk_int_select: got %h expected %h at %0t",
				clk_int_select, m_clk_int_sel, $time);
			reg_errors++;
		end
		if (cfg_rvalid !== m_rvalid) begin
			$display("ERROR cfg_rvalid: got %h expected %h at %0t",
				cfg_rvalid, m_rvalid, $time);
			reg_errors++;
		end
		if (m_rvalid && cfg_rdata !== m_rdata) begin
			$display("ERROR cfg_rdata: got %h expected %h at %0t",
				cfg_rdata, m_rdata, $time);
			reg_errors++;
		end
	endtask

	// outputs settle after the rising edge and are compared at the falling edge
	always @(negedge sel_fast_clock) begin
		if (cycle_count > 0) begin // the clock start at time zero is no cycle
			if (!rst_n) begin
				reset_model();
				check_outputs();
			end else begin
				check_outputs();
				advance_model();
			end
		end
	end

	always @(posedge sel_fast_clock)
		cycle_count++;

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic run_phase(input int phase);
		logic [31:0] rnd;
		int          r;
		logic        wr;
		logic        rd;
		reg_addr_t   addr;
		reg_data_t   wdata;
		logic        ext_act;
		for (int i = 0; i < PHASE_CYCLES; i++) begin
			@(posedge sel_fast_clock);
			rnd     = $urandom;
			r       = $urandom_range(99);
			wr      = 1'b0;
			rd      = 1'b0;
			addr    = rnd[17:16];
			wdata   = rnd[15:8];
			ext_act = clk_ext_active;
			case (phase)
				0: begin // internal source with reset values read first
					ext_act = 1'b0;
					if (i < 2) begin
						rd   = 1'b1;
						addr = reg_addr_t'(i);
					end else if (r < 10) begin
						rd   = 1'b1;
						addr = {1'b0, rnd[16]};
					end
				end
				1: begin // external source with edge_sel rewritten
					ext_act = 1'b1;
					if (r < 5) begin
						wr       = 1'b1;
						addr     = REG_MODE;
						wdata[1] = 1'b1; // keep polarity
					end else if (r < 15) begin
						rd = 1'b1;
					end
				end
				2: begin // polarity and source switching
					if (r < 6) begin
						wr   = 1'b1;
						addr = REG_MODE;
					end else if (r < 10) begin
						ext_act = ~clk_ext_active;
					end else if (r < 13) begin
						wr   = 1'b1;
						addr = REG_CLOCK;
					end else if (r < 20) begin
						rd = 1'b1;
					end
				end
				default: begin // counter readback and clears
					ext_act = 1'b1;
					if (r < 25) begin
						rd = 1'b1;
					end else if (r < 35) begin
						wr   = 1'b1;
						addr = {1'b1, rnd[16]};
					end else if (r < 40) begin
						wr   = 1'b1;
						rd   = 1'b1;
						addr = {1'b1, rnd[16]};
					end
				end
			endcase
			cfg_wr           <= wr;
			cfg_rd           <= rd;
			cfg_addr         <= addr;
			cfg_wdata        <= wdata;
			clk_ext_active   <= ext_act;
			int_fast_command <= rnd[0];
			ext_rise         <= rnd[1];
			ext_fall         <= rnd[2];
		end
	endtask

	initial begin
		rng_seed         = $urandom(SEED);
		rst_n            = 1'b0;
		cfg_wr           = 1'b0;
		cfg_rd           = 1'b0;
		cfg_addr         = '0;
		cfg_wdata        = '0;
		clk_ext_active   = 1'b0;
		int_fast_command = 1'b0;
		ext_rise         = 1'b0;
		ext_fall         = 1'b0;
		repeat (RESET_CYCLES) @(posedge sel_fast_clock);
		rst_n <= 1'b1;
		for (int p = 0; p < NUM_PHASES; p++)
			run_phase(p);
		@(posedge sel_fast_clock);
		cfg_wr <= 1'b0;
		cfg_rd <= 1'b0;
		repeat (4) @(posedge sel_fast_clock);
		$display("error counts: fast_command_out %0d, fast_command_fanout %0d, registers %0d",
			out_errors, fanout_errors, reg_errors);
		if (out_errors + fanout_errors + reg_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fast_control_fanout.f ====
verilog/fc_cfg_pkg.sv
verilog/fc_cmd_pkg.sv
verilog/fc_ctrl_if.sv
verilog/fc_config_regs.sv
verilog/int_command_sync.sv
verilog/ext_command_capture.sv
verilog/command_fanout.sv
verilog/fast_control_fanout.sv
verif/fast_control_fanout_tb.sv
